// ==== Bender.yml ====
package:
  name: softmax_engine

sources:
  - files:
      - softmax_pkg.sv
      - softmax_step_counter.sv
      - softmax_ctrl.sv
      - softmax_exp_sum.sv
      - fxp_div_pipe.sv
      - softmax_alpha_store.sv
      - softmax_top.sv
  - target: test
    files:
      - tb_softmax.sv

// ==== all.f ====
softmax_pkg.sv
softmax_step_counter.sv
softmax_ctrl.sv
softmax_exp_sum.sv
fxp_div_pipe.sv
softmax_alpha_store.sv
softmax_top.sv
tb_softmax.sv

// ==== fxp_div_pipe.sv ====
`timescale 1ns/1ns

module fxp_div_pipe (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          i_valid,
  input  logic [softmax_pkg::IDX_W-1:0] i_tag,
  input  logic [softmax_pkg::EXP_W-1:0] i_dividend,
  input  logic [softmax_pkg::SUM_W-1:0] i_divisor,
  output logic                          o_valid,
  output logic [softmax_pkg::IDX_W-1:0] o_tag,
  output logic [softmax_pkg::OUT_W-1:0] o_quotient
);

  // operands entering each stage
  logic [softmax_pkg::DIV_REM_W-1:0] rem_d [softmax_pkg::DIV_LATENCY];
  logic [softmax_pkg::SUM_W-1:0]     dvs_d [softmax_pkg::DIV_LATENCY];
  logic [softmax_pkg::OUT_W-1:0]     quo_d [softmax_pkg::DIV_LATENCY];
  // divisor aligned to the quotient bit of that stage
  logic [softmax_pkg::DIV_REM_W-1:0] trial [softmax_pkg::DIV_LATENCY];

  // stage output registers
  logic [softmax_pkg::DIV_REM_W-1:0] rem_q [softmax_pkg::DIV_LATENCY];
  logic [softmax_pkg::SUM_W-1:0]     dvs_q [softmax_pkg::DIV_LATENCY];
  logic [softmax_pkg::OUT_W-1:0]     quo_q [softmax_pkg::DIV_LATENCY];
  logic [softmax_pkg::IDX_W-1:0]     tag_q [softmax_pkg::DIV_LATENCY];
  logic                              vld_q [softmax_pkg::DIV_LATENCY];

  always_comb begin
    // numerator = dividend * 2**OUT_FRAC
    rem_d[0] = {{(softmax_pkg::DIV_REM_W - softmax_pkg::EXP_W - softmax_pkg::OUT_FRAC){1'b0}},
                i_dividend, {softmax_pkg::OUT_FRAC{1'b0}}};
    dvs_d[0] = i_divisor;
    quo_d[0] = '0;
    for (int s = 1; s < softmax_pkg::DIV_LATENCY; s++) begin
      rem_d[s] = rem_q[s-1];
      dvs_d[s] = dvs_q[s-1];
      quo_d[s] = quo_q[s-1];
    end
    // stage s decides quotient bit OUT_W-1-s, msb first
    for (int s = 0; s < softmax_pkg::DIV_LATENCY; s++) begin
      trial[s] = {{(softmax_pkg::DIV_REM_W - softmax_pkg::SUM_W){1'b0}}, dvs_d[s]}
                 << (softmax_pkg::OUT_W - 1 - s);
    end
  end

  // restoring step, remainder kept when the trial does not fit
  always_ff @(posedge clk) begin
    for (int s = 0; s < softmax_pkg::DIV_LATENCY; s++) begin
      dvs_q[s] <= dvs_d[s];
      if (rem_d[s] >= trial[s]) begin
        rem_q[s] <= rem_d[s] - trial[s];
        quo_q[s] <= {quo_d[s][softmax_pkg::OUT_W-2:0], 1'b1};
      end else begin
        rem_q[s] <= rem_d[s];
        quo_q[s] <= {quo_d[s][softmax_pkg::OUT_W-2:0], 1'b0};
      end
    end
    tag_q[0] <= i_tag;
    for (int s = 1; s < softmax_pkg::DIV_LATENCY; s++) begin
      tag_q[s] <= tag_q[s-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < softmax_pkg::DIV_LATENCY; s++) begin
        vld_q[s] <= 1'b0;
      end
    end else begin
      vld_q[0] <= i_valid;
      for (int s = 1; s < softmax_pkg::DIV_LATENCY; s++) begin
        vld_q[s] <= vld_q[s-1];
      end
    end
  end

  assign o_valid    = vld_q[softmax_pkg::DIV_LATENCY-1];
  assign o_tag      = tag_q[softmax_pkg::DIV_LATENCY-1];
  assign o_quotient = quo_q[softmax_pkg::DIV_LATENCY-1];

  // sum must be settled before the first issue
  assert property (@(posedge clk) disable iff (!rst_n) i_valid |-> (i_divisor != '0))
    else $error("divider issued with zero divisor");

endmodule

// ==== softmax_alpha_store.sv ====
`timescale 1ns/1ns

module softmax_alpha_store (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          i_clear,
  input  logic                          i_valid,
  input  logic [softmax_pkg::IDX_W-1:0] i_tag,
  input  logic [softmax_pkg::OUT_W-1:0] i_quotient,
  output logic [softmax_pkg::OUT_W-1:0] o_alpha [softmax_pkg::MAX_NODES]
);

  // clear on accept so unused nodes read zero
  always_ff @(posedge clk) begin
    if (!rst_n || i_clear) begin
      for (int i = 0; i < softmax_pkg::MAX_NODES; i++) begin
        o_alpha[i] <= '0;
      end
    end else if (i_valid) begin
      o_alpha[i_tag] <= i_quotient;
    end
  end

  // divider must be empty when a new request is loaded
  assert property (@(posedge clk) disable iff (!rst_n) i_clear |-> !i_valid)
    else $error("divider result arrived during clear");

endmodule

// ==== softmax_ctrl.sv ====
`timescale 1ns/1ns

module softmax_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           i_valid,
  input  logic [softmax_pkg::NODE_W-1:0] i_num_nodes,
  input  logic [softmax_pkg::CNT_W-1:0]  i_step_count,
  input  logic                           i_step_last,
  output logic                           o_step_clear,
  output logic                           o_step_enable,
  output logic [softmax_pkg::CNT_W-1:0]  o_step_limit,
  output logic                           o_load,
  output logic                           o_issue_valid,
  output logic [softmax_pkg::IDX_W-1:0]  o_issue_idx,
  output logic                           o_idle,
  output logic                           o_done
);

  softmax_pkg::state_t            state;
  softmax_pkg::state_t            state_next;
  logic [softmax_pkg::NODE_W-1:0] num_q;
  logic                           idle_q;
  logic                           accept;

  assign accept = i_valid && idle_q && (state == softmax_pkg::IDLE);

  always_comb begin
    state_next = state;
    case (state)
      softmax_pkg::IDLE: begin
        if (accept) begin
          state_next = softmax_pkg::LOAD;
        end
      end
      softmax_pkg::LOAD: begin
        state_next = softmax_pkg::REDUCE;
      end
      softmax_pkg::REDUCE: begin
        if (i_step_last) begin
          state_next = softmax_pkg::ISSUE;
        end
      end
      softmax_pkg::ISSUE: begin
        if (i_step_last) begin
          state_next = softmax_pkg::DRAIN;
        end
      end
      softmax_pkg::DRAIN: begin
        if (i_step_last) begin
          state_next = softmax_pkg::DONE;
        end
      end
      default: begin
        state_next = softmax_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= softmax_pkg::IDLE;
      num_q         <= '0;
      idle_q        <= 1'b1;
      o_done        <= 1'b0;
      o_issue_valid <= 1'b0;
    end else begin
      state         <= state_next;
      idle_q        <= (state == softmax_pkg::IDLE);
      o_done        <= (state == softmax_pkg::DONE);
      o_issue_valid <= (state == softmax_pkg::ISSUE);
      if (accept) begin
        num_q <= i_num_nodes;
      end
    end
  end

  // during ISSUE the count is the node index
  always_ff @(posedge clk) begin
    o_issue_idx <= i_step_count[softmax_pkg::IDX_W-1:0];
  end

  // per-phase terminal count
  always_comb begin
    case (state)
      softmax_pkg::REDUCE: o_step_limit = softmax_pkg::CNT_W'(softmax_pkg::TREE_DEPTH - 1);
      softmax_pkg::ISSUE:  o_step_limit = softmax_pkg::CNT_W'(num_q - 1'b1);
      softmax_pkg::DRAIN:  o_step_limit = softmax_pkg::CNT_W'(softmax_pkg::DIV_LATENCY);
      default:             o_step_limit = '0;
    endcase
  end

  assign o_step_enable = (state == softmax_pkg::REDUCE) || (state == softmax_pkg::ISSUE) ||
                         (state == softmax_pkg::DRAIN);
  // restart from zero on every phase change
  assign o_step_clear  = !o_step_enable || i_step_last;
  assign o_load        = (state == softmax_pkg::LOAD);
  assign o_idle        = idle_q;

  assert property (@(posedge clk) disable iff (!rst_n) o_done |=> !o_done)
    else $error("done held for more than one cycle");

  // a zero count would wrap the issue limit
  assert property (@(posedge clk) disable iff (!rst_n)
    (state == softmax_pkg::LOAD) |-> (num_q != '0))
    else $error("request accepted with zero nodes");

endmodule

// ==== softmax_exp_sum.sv ====
`timescale 1ns/1ns

module softmax_exp_sum (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           i_load,
  input  logic [softmax_pkg::NODE_W-1:0] i_num_nodes,
  input  logic [softmax_pkg::COEF_W-1:0] i_coef [softmax_pkg::MAX_NODES],
  input  logic [softmax_pkg::IDX_W-1:0]  i_sel,
  output logic [softmax_pkg::EXP_W-1:0]  o_exp_sel,
  output logic [softmax_pkg::SUM_W-1:0]  o_sum
);

  logic [softmax_pkg::EXP_W-1:0] exp_q  [softmax_pkg::MAX_NODES];
  logic [softmax_pkg::EXP_W:0]   lvl1_q [softmax_pkg::MAX_NODES/2];
  logic [softmax_pkg::EXP_W+1:0] lvl2_q [softmax_pkg::MAX_NODES/4];
  logic [softmax_pkg::SUM_W-1:0] sum_q;

  // 2**c, unused nodes contribute nothing to the sum
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < softmax_pkg::MAX_NODES; i++) begin
        exp_q[i] <= '0;
      end
    end else if (i_load) begin
      for (int i = 0; i < softmax_pkg::MAX_NODES; i++) begin
        if (i < i_num_nodes) begin
          exp_q[i] <= softmax_pkg::EXP_W'(1) << i_coef[i];
        end else begin
          exp_q[i] <= '0;
        end
      end
    end
  end

  // tree runs freely, the sum settles TREE_DEPTH cycles after load
  always_ff @(posedge clk) begin
    for (int i = 0; i < softmax_pkg::MAX_NODES / 2; i++) begin
      lvl1_q[i] <= {1'b0, exp_q[2*i]} + {1'b0, exp_q[2*i+1]};
    end
    for (int i = 0; i < softmax_pkg::MAX_NODES / 4; i++) begin
      lvl2_q[i] <= {1'b0, lvl1_q[2*i]} + {1'b0, lvl1_q[2*i+1]};
    end
    sum_q <= {1'b0, lvl2_q[0]} + {1'b0, lvl2_q[1]};
  end

  // dividend for the node being issued
  assign o_exp_sel = exp_q[i_sel];
  assign o_sum     = sum_q;

endmodule

// ==== softmax_input.txt ====
# nodes, coef0..coef7, expected alpha0..alpha7, all hex, alpha in Q1.15
# coefficients at or beyond the node count are ignored and their alphas read zero
8  0 0 0 0 0 0 0 0  1000 1000 1000 1000 1000 1000 1000 1000
1  5 3 3 3 3 3 3 3  8000 0000 0000 0000 0000 0000 0000 0000
8  f f f f f f f f  1000 1000 1000 1000 1000 1000 1000 1000
4  0 1 2 3 f f f f  0888 1111 2222 4444 0000 0000 0000 0000
2  f 0 9 9 9 9 9 9  7fff 0000 0000 0000 0000 0000 0000 0000
3  1 1 1 0 0 0 0 0  2aaa 2aaa 2aaa 0000 0000 0000 0000 0000
8  0 1 2 3 4 5 6 7  0080 0101 0202 0404 0808 1010 2020 4040
5  f f f f f 1 2 3  1999 1999 1999 1999 1999 0000 0000 0000
7  2 2 2 2 2 2 2 c  1249 1249 1249 1249 1249 1249 1249 0000
2  0 0 7 7 7 7 7 7  4000 4000 0000 0000 0000 0000 0000 0000
1  0 0 0 0 0 0 0 0  8000 0000 0000 0000 0000 0000 0000 0000
6  3 3 3 3 3 3 a b  1555 1555 1555 1555 1555 1555 0000 0000
3  f e d 0 0 0 0 0  4924 2492 1249 0000 0000 0000 0000 0000
8  f 0 0 0 0 0 0 0  7ff9 0000 0000 0000 0000 0000 0000 0000
4  4 4 4 4 f f f f  2000 2000 2000 2000 0000 0000 0000 0000
8  1 0 1 0 1 0 1 0  1555 0aaa 1555 0aaa 1555 0aaa 1555 0aaa
5  0 1 2 3 4 5 6 7  0421 0842 1084 2108 4210 0000 0000 0000
2  8 7 0 0 0 0 0 0  5555 2aaa 0000 0000 0000 0000 0000 0000
3  a a a 1 1 1 1 1  2aaa 2aaa 2aaa 0000 0000 0000 0000 0000
1  f f f f f f f f  8000 0000 0000 0000 0000 0000 0000 0000
6  0 0 0 0 0 f 0 0  0000 0000 0000 0000 0000 7ffb 0000 0000
8  2 2 2 2 2 2 2 2  1000 1000 1000 1000 1000 1000 1000 1000
7  0 1 0 1 0 1 0 f  0ccc 1999 0ccc 1999 0ccc 1999 0ccc 0000
4  c d e f 0 0 0 0  0888 1111 2222 4444 0000 0000 0000 0000

// ==== softmax_pkg.sv ====
package softmax_pkg;

  // vector length and node count
  localparam int MAX_NODES = 8;
  localparam int NODE_W    = 4;
  localparam int IDX_W     = 3;

  // coefficient and exponential widths
  localparam int COEF_W = 4;
  localparam int EXP_W  = 16;

  // sum of eight values up to 2**15
  localparam int SUM_W = 19;

  // alpha format is Q1.15
  localparam int OUT_W    = 16;
  localparam int OUT_FRAC = 15;

  // pipeline depths
  localparam int TREE_DEPTH  = 3;
  localparam int DIV_LATENCY = 16;

  // divider remainder must hold the divisor shifted by the top quotient bit
  localparam int DIV_REM_W = OUT_W + SUM_W;

  // step counter, large enough for the drain phase
  localparam int CNT_W = 5;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    REDUCE,
    ISSUE,
    DRAIN,
    DONE
  } state_t;

endpackage

// ==== softmax_step_counter.sv ====
`timescale 1ns/1ns

module softmax_step_counter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          i_clear,
  input  logic                          i_enable,
  input  logic [softmax_pkg::CNT_W-1:0] i_limit,
  output logic [softmax_pkg::CNT_W-1:0] o_count,
  output logic                          o_last
);

  // clear wins over enable, count parks at the limit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_count <= '0;
    end else if (i_clear) begin
      o_count <= '0;
    end else if (i_enable && (o_count != i_limit)) begin
      o_count <= o_count + 1'b1;
    end
  end

  assign o_last = (o_count == i_limit);

  // controller must clear whenever it switches to a new limit
  assert property (@(posedge clk) disable iff (!rst_n) o_count <= i_limit)
    else $error("step counter above limit: count %0d limit %0d", o_count, i_limit);

endmodule

// ==== softmax_top.sv ====
`timescale 1ns/1ns

module softmax_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           i_valid,
  input  logic [softmax_pkg::NODE_W-1:0] i_num_nodes,
  input  logic [softmax_pkg::COEF_W-1:0] i_coef [softmax_pkg::MAX_NODES],
  output logic                           o_idle,
  output logic                           o_done,
  output logic [softmax_pkg::OUT_W-1:0]  o_alpha [softmax_pkg::MAX_NODES]
);

  logic                          step_clear;
  logic                          step_enable;
  logic [softmax_pkg::CNT_W-1:0] step_limit;
  logic [softmax_pkg::CNT_W-1:0] step_count;
  logic                          step_last;
  logic                          load;
  logic                          issue_valid;
  logic [softmax_pkg::IDX_W-1:0] issue_idx;
  logic [softmax_pkg::EXP_W-1:0] exp_sel;
  logic [softmax_pkg::SUM_W-1:0] sum;
  logic                          div_valid;
  logic [softmax_pkg::IDX_W-1:0] div_tag;
  logic [softmax_pkg::OUT_W-1:0] div_quotient;

  softmax_ctrl softmax_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_valid       (i_valid),
    .i_num_nodes   (i_num_nodes),
    .i_step_count  (step_count),
    .i_step_last   (step_last),
    .o_step_clear  (step_clear),
    .o_step_enable (step_enable),
    .o_step_limit  (step_limit),
    .o_load        (load),
    .o_issue_valid (issue_valid),
    .o_issue_idx   (issue_idx),
    .o_idle        (o_idle),
    .o_done        (o_done)
  );

  softmax_step_counter softmax_step_counter_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_clear  (step_clear),
    .i_enable (step_enable),
    .i_limit  (step_limit),
    .o_count  (step_count),
    .o_last   (step_last)
  );

  softmax_exp_sum softmax_exp_sum_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_load      (load),
    .i_num_nodes (i_num_nodes),
    .i_coef      (i_coef),
    .i_sel       (issue_idx),
    .o_exp_sel   (exp_sel),
    .o_sum       (sum)
  );

  fxp_div_pipe fxp_div_pipe_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_valid    (issue_valid),
    .i_tag      (issue_idx),
    .i_dividend (exp_sel),
    .i_divisor  (sum),
    .o_valid    (div_valid),
    .o_tag      (div_tag),
    .o_quotient (div_quotient)
  );

  softmax_alpha_store softmax_alpha_store_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_clear    (load),
    .i_valid    (div_valid),
    .i_tag      (div_tag),
    .i_quotient (div_quotient),
    .o_alpha    (o_alpha)
  );

  // every quotient lands before the controller reaches DONE
  assert property (@(posedge clk) disable iff (!rst_n)
    div_valid |-> (softmax_ctrl_inst.state inside {softmax_pkg::ISSUE, softmax_pkg::DRAIN}))
    else $error("divider result outside issue or drain phase");

endmodule

// ==== tb_softmax.sv ====
`timescale 1ns/1ns

module tb_softmax;

  logic                           clk = 1'b0;
  logic                           rst_n;
  logic                           i_valid;
  logic [softmax_pkg::NODE_W-1:0] i_num_nodes;
  logic [softmax_pkg::COEF_W-1:0] i_coef [softmax_pkg::MAX_NODES];
  logic                           o_idle;
  logic                           o_done;
  logic [softmax_pkg::OUT_W-1:0]  o_alpha [softmax_pkg::MAX_NODES];

  // one entry per request line of the data file
  logic [softmax_pkg::NODE_W-1:0]                        nodes_q [$];
  logic [softmax_pkg::MAX_NODES*softmax_pkg::COEF_W-1:0] coef_q  [$];
  logic [softmax_pkg::MAX_NODES*softmax_pkg::OUT_W-1:0]  alpha_q [$];

  int errors      = 0;
  int checks      = 0;
  int req_idx     = -1;
  int cycle_count = 0;
  int cycle_limit = 0;

  softmax_top softmax_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_valid     (i_valid),
    .i_num_nodes (i_num_nodes),
    .i_coef      (i_coef),
    .o_idle      (o_idle),
    .o_done      (o_done),
    .o_alpha     (o_alpha)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic compare_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAILED %s: expected 0x%04h, got 0x%04h (request %0d)",
               name, expected, actual, req_idx);
    end
  endtask

  task automatic confirm_condition(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("request %0d: %s", req_idx, what);
    end
  endtask

  task automatic drive_inputs(input logic valid, input logic [softmax_pkg::NODE_W-1:0] n,
                              input logic [softmax_pkg::MAX_NODES*softmax_pkg::COEF_W-1:0] c);
    i_valid     <= valid;
    i_num_nodes <= n;
    for (int i = 0; i < softmax_pkg::MAX_NODES; i++) begin
      i_coef[i] <= c[softmax_pkg::COEF_W*i +: softmax_pkg::COEF_W];
    end
  endtask

  task automatic check_alphas(input logic [softmax_pkg::MAX_NODES*softmax_pkg::OUT_W-1:0] exp);
    for (int i = 0; i < softmax_pkg::MAX_NODES; i++) begin
      compare_value($sformatf("o_alpha[%0d]", i), exp[softmax_pkg::OUT_W*i +: softmax_pkg::OUT_W],
                    o_alpha[i]);
    end
  endtask

  // no request running, done must stay quiet
  task automatic idle_cycles(input int count);
    repeat (count) begin
      @(posedge clk);
      @(negedge clk);
      confirm_condition(!o_done, "o_done pulsed while no request was running");
    end
  endtask

  task automatic load_vectors();
    int                                                    fd;
    int                                                    cnt;
    string                                                 line;
    logic [15:0]                                           fld [17];
    logic [softmax_pkg::MAX_NODES*softmax_pkg::COEF_W-1:0] coefs;
    logic [softmax_pkg::MAX_NODES*softmax_pkg::OUT_W-1:0]  alphas;
    fd = $fopen("softmax_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open softmax_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                        fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                        fld[15], fld[16]);
          if (cnt == 17) begin
            for (int i = 0; i < softmax_pkg::MAX_NODES; i++) begin
              coefs[softmax_pkg::COEF_W*i +: softmax_pkg::COEF_W] = fld[1+i][3:0];
              alphas[softmax_pkg::OUT_W*i +: softmax_pkg::OUT_W]  = fld[9+i];
            end
            nodes_q.push_back(fld[0][softmax_pkg::NODE_W-1:0]);
            coef_q.push_back(coefs);
            alpha_q.push_back(alphas);
          end else if (cnt > 0) begin
            errors++;
            $display("malformed line in softmax_input.txt: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    if (nodes_q.size() == 0) begin
      errors++;
      $display("no requests found in softmax_input.txt");
    end
  endtask

  initial begin
    int n;
    int gap;
    int spur_k;
    void'($urandom(32'h71805db8));
    rst_n <= 1'b0;
    drive_inputs(1'b0, '0, '0);
    load_vectors();
    cycle_limit = nodes_q.size() * (softmax_pkg::MAX_NODES + 22 + 4) + 50;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    confirm_condition(o_idle, "o_idle low after reset");
    confirm_condition(!o_done, "o_done high after reset");
    check_alphas('0);

    for (int r = 0; r < nodes_q.size(); r++) begin
      req_idx = r;
      n       = nodes_q[r];
      gap     = $urandom % 4;
      spur_k  = 2 + ($urandom % (n + 10));
      idle_cycles(gap);
      while (o_idle !== 1'b1) begin
        @(negedge clk);
      end
      @(posedge clk);
      drive_inputs(1'b1, nodes_q[r], coef_q[r]);
      // accepting edge
      @(posedge clk);
      i_valid <= 1'b0;
      for (int k = 1; k <= n + 22; k++) begin
        @(posedge clk);
        if (k == spur_k || k == n + 22) begin
          // strobe with unrelated data while o_idle is low
          drive_inputs(1'b1, softmax_pkg::NODE_W'(1 + $urandom % 8), $urandom);
        end else begin
          i_valid <= 1'b0;
        end
        @(negedge clk);
        confirm_condition(!o_idle, $sformatf("o_idle high %0d cycles after accept", k));
        if (k < n + 22) begin
          confirm_condition(!o_done,
                            $sformatf("o_done pulsed %0d cycles after accept, expected %0d",
                                      k, n + 22));
        end else begin
          confirm_condition(o_done, $sformatf("o_done missing %0d cycles after accept", k));
        end
      end
      check_alphas(alpha_q[r]);
      @(posedge clk);
      i_valid <= 1'b0;
      @(negedge clk);
      confirm_condition(!o_done, "o_done held for more than one cycle");
      confirm_condition(o_idle, "o_idle did not return high after done");
      // strobe from the done cycle must not have started a request
      @(posedge clk);
      @(negedge clk);
      confirm_condition(o_idle, "request accepted from a strobe while o_idle was low");
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // watchdog on total run length
  initial begin
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
    end
    $display("timeout after %0d cycles, errors so far: %0d", cycle_count, errors);
    $display("Verification failed");
    $finish;
  end

endmodule
